/* hdl/debug_io.sv */
module debug_io #(
   parameter int  SCRATCH_WORDS = 16,
   parameter int  PRINT_DEPTH   = 8,
   parameter int  LOG_DEPTH     = 4,
   localparam int IDX_W         = (SCRATCH_WORDS > 1) ? $clog2(SCRATCH_WORDS) : 1
) (
   input  logic                     nw,
   input  logic                     rst,
   input  debug_io_pkg::bus_req_t   req,
   input  logic                     print_pop,
   output debug_io_pkg::print_rec_t print_head,
   output logic                     print_empty,
   output logic                     print_overflow,
   input  logic                     log_pop,
   output debug_io_pkg::io_log_t    log_head,
   output logic                     log_empty,
   output logic                     log_overflow,
   output logic [15:0]              rdata,
   output logic                     rdata_valid,
   output logic                     nhalt,
   output logic [15:0]              pass_count,
   output logic [15:0]              fail_count
);

   logic                     halted;                   // Gates acceptance in the decoder.
   logic                     halt_evt;
   logic                     pass_evt;
   logic                     fail_evt;
   logic                     print_push;
   debug_io_pkg::print_rec_t print_rec;
   logic                     log_push;
   debug_io_pkg::io_log_t    log_rec;
   logic                     scratch_we;
   logic [IDX_W-1:0]         scratch_addr;
   logic [15:0]              scratch_data;
   logic                     rd_evt;
   debug_io_pkg::io_addr_t   rd_addr;

   //////////////////////////////////////////////////
   // Decoder
   //////////////////////////////////////////////////

   io_decode #(.SCRATCH_WORDS(SCRATCH_WORDS)) io_decode_i (
      .nw(nw), .rst(rst), .req(req), .halted(halted),
      .halt_evt(halt_evt), .pass_evt(pass_evt), .fail_evt(fail_evt),
      .print_push(print_push), .print_rec(print_rec),
      .log_push(log_push), .log_rec(log_rec),
      .scratch_we(scratch_we), .scratch_addr(scratch_addr), .scratch_data(scratch_data),
      .rd_evt(rd_evt), .rd_addr(rd_addr)
   );

   //////////////////////////////////////////////////
   // Host queues
   //////////////////////////////////////////////////

   event_fifo #(.payload_t(debug_io_pkg::print_rec_t), .DEPTH(PRINT_DEPTH)) print_fifo_i (
      .nw(nw), .rst(rst), .push(print_push), .din(print_rec), .pop(print_pop),
      .head(print_head), .empty(print_empty), .overflow(print_overflow)
   );

   event_fifo #(.payload_t(debug_io_pkg::io_log_t), .DEPTH(LOG_DEPTH)) log_fifo_i (
      .nw(nw), .rst(rst), .push(log_push), .din(log_rec), .pop(log_pop),
      .head(log_head), .empty(log_empty), .overflow(log_overflow)
   );

   //////////////////////////////////////////////////
   // Scratch and status
   //////////////////////////////////////////////////

   io_scratch #(.SCRATCH_WORDS(SCRATCH_WORDS)) io_scratch_i (
      .nw(nw), .rst(rst), .we(scratch_we), .waddr(scratch_addr), .wdata(scratch_data),
      .rd(rd_evt), .raddr(rd_addr), .rdata(rdata), .rdata_valid(rdata_valid)
   );

   halt_status halt_status_i (
      .nw(nw), .rst(rst), .halt_evt(halt_evt), .pass_evt(pass_evt), .fail_evt(fail_evt),
      .halted(halted), .nhalt(nhalt), .pass_count(pass_count), .fail_count(fail_count)
   );

endmodule

/* hdl/debug_io_pkg.sv */
package debug_io_pkg;

   //////////////////////////////////////////////////
   // Address map
   //////////////////////////////////////////////////

   typedef logic [9:0] io_addr_t;                      // Only the low 10 bits are decoded.

   localparam io_addr_t ADDR_HALT    = 10'h007;        // Write halts the processor.
   localparam io_addr_t ADDR_PRINTA  = 10'h3f0;        // Print the bus address.
   localparam io_addr_t ADDR_PRINTC  = 10'h3f1;        // Print a character.
   localparam io_addr_t ADDR_PRINTS  = 10'h3f2;        // Print signed decimal.
   localparam io_addr_t ADDR_PRINTU  = 10'h3f3;        // Print unsigned decimal.
   localparam io_addr_t ADDR_PRINTH  = 10'h3f4;        // Print hex.
   localparam io_addr_t ADDR_PRINTB  = 10'h3f5;        // Print binary.
   localparam io_addr_t ADDR_SPACE   = 10'h3f6;        // Print a space.
   localparam io_addr_t ADDR_NEWLINE = 10'h3f7;        // Print a newline.
   localparam io_addr_t ADDR_PASS    = 10'h3fe;        // Assertion passed.
   localparam io_addr_t ADDR_FAIL    = 10'h3ff;        // Assertion failed, halts too.

   localparam logic [15:0] READ_DEFAULT = 16'hbeef;    // Unmapped or unwritten read data.

   //////////////////////////////////////////////////
   // Bus request and record types
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [15:0] addr;                               // Full bus address.
      logic [15:0] wdata;                              // Write data.
      logic        io;                                 // I/O space request.
      logic        rd;                                 // Read strobe.
      logic        wr;                                 // Write strobe.
   } bus_req_t;

   // Order follows addresses 0x3f0 to 0x3f7.
   typedef enum logic [2:0] {
      PRINT_ADDRESS,
      PRINT_CHAR,
      PRINT_SIGNED,
      PRINT_UNSIGNED,
      PRINT_HEX,
      PRINT_BINARY,
      PRINT_SPACE,
      PRINT_NEWLINE
   } print_kind_t;

   typedef struct packed {
      print_kind_t kind;                               // How the host formats the value.
      logic [15:0] value;                              // Address, data or fixed char code.
   } print_rec_t;

   typedef struct packed {
      io_addr_t    addr;                               // Decoded write address.
      logic [15:0] data;                               // Write data.
   } io_log_t;

endpackage

/* hdl/event_fifo.sv */
module event_fifo #(
   parameter type payload_t = logic [15:0],
   parameter int  DEPTH     = 8
) (
   input  logic     nw,
   input  logic     rst,
   input  logic     push,
   input  payload_t din,
   input  logic     pop,
   output payload_t head,
   output logic     empty,
   output logic     overflow
);

   localparam int AW = $clog2(DEPTH);                  // Index width.

   payload_t    mem [DEPTH];                           // Entry storage.
   logic [AW:0] wp;                                    // Write pointer with wrap bit.
   logic [AW:0] rp;                                    // Read pointer with wrap bit.
   logic        full;
   logic        do_push;
   logic        do_pop;

   //////////////////////////////////////////////////
   // Pointer compare
   //////////////////////////////////////////////////

   assign empty   = (wp == rp);
   assign full    = (wp[AW] != rp[AW]) && (wp[AW-1:0] == rp[AW-1:0]);
   assign do_pop  = pop && !empty;                     // Pop on empty is ignored.
   assign do_push = push && (!full || do_pop);         // Full with pop frees a slot.
   assign head    = mem[rp[AW-1:0]];                   // Oldest entry.

   always_ff @(posedge nw) begin
      if (do_push) begin
         mem[wp[AW-1:0]] <= din;
      end
   end

   always_ff @(posedge nw) begin
      if (rst) begin
         wp       <= '0;
         rp       <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_push) begin
            wp <= wp + 1'b1;
         end
         if (do_pop) begin
            rp <= rp + 1'b1;
         end
         if (push && !do_push) begin
            overflow <= 1'b1;                          // Sticky until reset.
         end
      end
   end

endmodule

/* hdl/halt_status.sv */
module halt_status (
   input  logic        nw,
   input  logic        rst,
   input  logic        halt_evt,
   input  logic        pass_evt,
   input  logic        fail_evt,
   output logic        halted,
   output logic        nhalt,
   output logic [15:0] pass_count,
   output logic [15:0] fail_count
);

   assign nhalt = !halted;                             // Active low halt to the processor.

   //////////////////////////////////////////////////
   // Halt latch
   //////////////////////////////////////////////////

   always_ff @(posedge nw) begin
      if (rst) begin
         halted <= 1'b0;
      end else if (halt_evt) begin
         halted <= 1'b1;                               // Held until reset.
      end
   end

   //////////////////////////////////////////////////
   // Assertion counters
   //////////////////////////////////////////////////

   always_ff @(posedge nw) begin
      if (rst) begin
         pass_count <= '0;
         fail_count <= '0;
      end else begin
         if (pass_evt && (pass_count != '1)) begin
            pass_count <= pass_count + 16'd1;          // Saturates at 0xffff.
         end
         if (fail_evt && (fail_count != '1)) begin
            fail_count <= fail_count + 16'd1;
         end
      end
   end

endmodule

/* hdl/io_decode.sv */
module io_decode #(
   parameter int  SCRATCH_WORDS = 16,
   localparam int IDX_W         = (SCRATCH_WORDS > 1) ? $clog2(SCRATCH_WORDS) : 1
) (
   input  logic                     nw,
   input  logic                     rst,
   input  debug_io_pkg::bus_req_t   req,
   input  logic                     halted,
   output logic                     halt_evt,
   output logic                     pass_evt,
   output logic                     fail_evt,
   output logic                     print_push,
   output debug_io_pkg::print_rec_t print_rec,
   output logic                     log_push,
   output debug_io_pkg::io_log_t    log_rec,
   output logic                     scratch_we,
   output logic [IDX_W-1:0]         scratch_addr,
   output logic [15:0]              scratch_data,
   output logic                     rd_evt,
   output debug_io_pkg::io_addr_t   rd_addr
);

   debug_io_pkg::bus_req_t    req_q;                   // Request sampled at edge 0.
   logic                      acc_q;                   // Sampled request was accepted.
   debug_io_pkg::io_addr_t    a;                       // Masked address of sampled request.
   debug_io_pkg::print_kind_t print_kind;
   logic [15:0]               print_value;
   logic                      accept;
   logic                      wr_acc;                  // Accepted write.
   logic                      halting_q;               // Accepted halt or fail write in flight.
   logic                      is_print;
   logic                      is_generic;
   logic                      in_scratch;

   //////////////////////////////////////////////////
   // Acceptance and sampling
   //////////////////////////////////////////////////

   assign a         = req_q.addr[9:0];                 // Upper bits are not decoded.
   assign wr_acc    = acc_q && req_q.wr;
   assign halting_q = wr_acc && (a == debug_io_pkg::ADDR_HALT || a == debug_io_pkg::ADDR_FAIL);

   // Halt still in the pipeline blocks new requests too.
   assign accept = req.io && (req.rd ^ req.wr) && !halted && !halting_q && !halt_evt;

   always_ff @(posedge nw) begin
      req_q <= req;                                    // Payload, no reset.
      if (rst) begin
         acc_q <= 1'b0;
      end else begin
         acc_q <= accept;
      end
   end

   //////////////////////////////////////////////////
   // Classification
   //////////////////////////////////////////////////

   assign is_print   = (a >= debug_io_pkg::ADDR_PRINTA) && (a <= debug_io_pkg::ADDR_NEWLINE);
   assign is_generic = !is_print && (a != debug_io_pkg::ADDR_HALT) &&
                       (a != debug_io_pkg::ADDR_PASS) && (a != debug_io_pkg::ADDR_FAIL);
   assign in_scratch = int'(a) < SCRATCH_WORDS;        // Word backed by the register file.
   assign print_kind = debug_io_pkg::print_kind_t'(a[2:0]);

   always_comb begin
      case (print_kind)
         debug_io_pkg::PRINT_ADDRESS: print_value = req_q.addr;  // Full 16-bit address.
         debug_io_pkg::PRINT_SPACE:   print_value = 16'd32;
         debug_io_pkg::PRINT_NEWLINE: print_value = 16'd10;
         default:                     print_value = req_q.wdata;
      endcase
   end

   always_ff @(posedge nw) begin
      if (rst) begin
         halt_evt   <= 1'b0;
         pass_evt   <= 1'b0;
         fail_evt   <= 1'b0;
         print_push <= 1'b0;
         log_push   <= 1'b0;
         scratch_we <= 1'b0;
         rd_evt     <= 1'b0;
      end else begin
         halt_evt   <= halting_q;                      // Fail halts as well.
         pass_evt   <= wr_acc && (a == debug_io_pkg::ADDR_PASS);
         fail_evt   <= wr_acc && (a == debug_io_pkg::ADDR_FAIL);
         print_push <= wr_acc && is_print;
         log_push   <= wr_acc && is_generic;
         scratch_we <= wr_acc && is_generic && in_scratch;
         rd_evt     <= acc_q && req_q.rd;              // Any I/O read.
      end
   end

   always_ff @(posedge nw) begin
      print_rec.kind  <= print_kind;
      print_rec.value <= print_value;
      log_rec.addr    <= a;
      log_rec.data    <= req_q.wdata;
      scratch_addr    <= a[IDX_W-1:0];
      scratch_data    <= req_q.wdata;
      rd_addr         <= a;
   end

endmodule

/* hdl/io_scratch.sv */
module io_scratch #(
   parameter int  SCRATCH_WORDS = 16,
   localparam int IDX_W         = (SCRATCH_WORDS > 1) ? $clog2(SCRATCH_WORDS) : 1
) (
   input  logic                   nw,
   input  logic                   rst,
   input  logic                   we,
   input  logic [IDX_W-1:0]       waddr,
   input  logic [15:0]            wdata,
   input  logic                   rd,
   input  debug_io_pkg::io_addr_t raddr,
   output logic [15:0]            rdata,
   output logic                   rdata_valid
);

   logic [15:0] mem [SCRATCH_WORDS];                   // Scratch words.
   logic        in_range;                              // Read hits a scratch word.

   assign in_range = int'(raddr) < SCRATCH_WORDS;

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   always_ff @(posedge nw) begin
      if (rst) begin
         for (int i = 0; i < SCRATCH_WORDS; i++) begin
            mem[i] <= debug_io_pkg::READ_DEFAULT;      // Unwritten words read 0xbeef.
         end
      end else if (we) begin
         mem[waddr] <= wdata;
      end
   end

   //////////////////////////////////////////////////
   // Read port
   //////////////////////////////////////////////////

   always_ff @(posedge nw) begin
      if (rd) begin
         rdata <= in_range ? mem[raddr[IDX_W-1:0]] : debug_io_pkg::READ_DEFAULT;
      end                                              // Otherwise hold last read.
   end

   always_ff @(posedge nw) begin
      if (rst) begin
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= rd;                            // One cycle per read.
      end
   end

endmodule

/* tb/debug_io_tb.sv */
module debug_io_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int SCRATCH_WORDS  = 16;
   localparam int PRINT_DEPTH    = 8;
   localparam int LOG_DEPTH      = 4;
   localparam int STIM_CYCLES    = 600;                // Rough length of all tests.
   localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

   logic                     nw;
   logic                     rst;
   debug_io_pkg::bus_req_t   req;
   logic                     print_pop;
   logic                     log_pop;
   debug_io_pkg::print_rec_t print_head;
   debug_io_pkg::io_log_t    log_head;
   logic                     print_empty;
   logic                     print_overflow;
   logic                     log_empty;
   logic                     log_overflow;
   logic [15:0]              rdata;
   logic                     rdata_valid;
   logic                     nhalt;
   logic [15:0]              pass_count;
   logic [15:0]              fail_count;

   debug_io_pkg::print_rec_t exp_print [$];            // Expected print queue.
   debug_io_pkg::io_log_t    exp_log [$];              // Expected log queue.
   logic [15:0]              exp_scratch [SCRATCH_WORDS];
   logic [15:0]              exp_pass = '0;
   logic [15:0]              exp_fail = '0;
   logic [15:0]              exp_rdata = '0;           // Data due for the last read.
   logic                     exp_rd = 1'b0;            // High for the cycle of an accepted read.
   logic                     exp_halted = 1'b0;
   logic                     exp_print_ovf = 1'b0;
   logic                     exp_log_ovf = 1'b0;
   int                       cycles = 0;

   debug_io #(.SCRATCH_WORDS(SCRATCH_WORDS), .PRINT_DEPTH(PRINT_DEPTH), .LOG_DEPTH(LOG_DEPTH))
   debug_io_i (
      .nw(nw), .rst(rst), .req(req), .print_pop(print_pop), .print_head(print_head),
      .print_empty(print_empty), .print_overflow(print_overflow), .log_pop(log_pop),
      .log_head(log_head), .log_empty(log_empty), .log_overflow(log_overflow),
      .rdata(rdata), .rdata_valid(rdata_valid), .nhalt(nhalt),
      .pass_count(pass_count), .fail_count(fail_count)
   );

   initial begin
      nw = 1'b0;
      forever #4 nw = ~nw;                             // 8 ns period.
   end

   always @(posedge nw) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////////////////////////
   // Checks, model state sampled three edges back
   //////////////////////////////////////////////////

   counters_ok: assert property (@(posedge nw) disable iff (rst)
      pass_count == $past(exp_pass, 3) && fail_count == $past(exp_fail, 3))
      else report_error("pass or fail count differs from model");
   nhalt_ok: assert property (@(posedge nw) disable iff (rst) nhalt == !$past(exp_halted, 3))
      else report_error("nhalt differs from model");
   overflow_ok: assert property (@(posedge nw) disable iff (rst)
      print_overflow == $past(exp_print_ovf, 3) && log_overflow == $past(exp_log_ovf, 3))
      else report_error("overflow flag differs from model");
   rd_valid_ok: assert property (@(posedge nw) disable iff (rst)
      rdata_valid == $past(exp_rd, 3))
      else report_error("rdata_valid differs from model");
   rdata_ok: assert property (@(posedge nw) disable iff (rst)
      rdata_valid |-> rdata == $past(exp_rdata, 3))
      else report_error($sformatf("rdata %h differs from model", rdata));

   task automatic report_error(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "check failed");
   endtask

   task automatic check_heads();                       // Only with the pipeline idle.
      assert (print_empty == (exp_print.size() == 0)) else report_error("print_empty wrong");
      if (exp_print.size() > 0) begin
         assert (print_head == exp_print[0])
            else report_error($sformatf("print_head %h, expected %h", print_head, exp_print[0]));
      end
      assert (log_empty == (exp_log.size() == 0)) else report_error("log_empty wrong");
      if (exp_log.size() > 0) begin
         assert (log_head == exp_log[0])
            else report_error($sformatf("log_head %h, expected %h", log_head, exp_log[0]));
      end
   endtask

   task automatic drain_queues();
      while (exp_print.size() > 0 || exp_log.size() > 0) begin
         check_heads();
         print_pop = exp_print.size() > 0;
         log_pop   = exp_log.size() > 0;
         if (print_pop) void'(exp_print.pop_front());
         if (log_pop) void'(exp_log.pop_front());
         @(negedge nw);
         print_pop = 1'b0;
         log_pop   = 1'b0;
      end
      check_heads();
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      exp_print.delete();
      exp_log.delete();
      foreach (exp_scratch[i]) exp_scratch[i] = 16'hbeef;  // Unwritten words.
      exp_pass      = '0;
      exp_fail      = '0;
      exp_halted    = 1'b0;
      exp_print_ovf = 1'b0;
      exp_log_ovf   = 1'b0;
      repeat (4) @(negedge nw);
      rst = 1'b0;
   endtask

   function automatic debug_io_pkg::bus_req_t make_req(input logic [15:0] addr,
      input logic [15:0] data, input logic io, input logic rd, input logic wr);
      return '{addr: addr, wdata: data, io: io, rd: rd, wr: wr};
   endfunction

   //////////////////////////////////////////////////
   // Request driver and reference model
   //////////////////////////////////////////////////

   task automatic drive_req(input debug_io_pkg::bus_req_t r);
      debug_io_pkg::io_addr_t   a;
      debug_io_pkg::print_rec_t p;
      debug_io_pkg::io_log_t    l;
      a   = r.addr[9:0];                               // Only 10 bits decode.
      req = r;
      if (r.io && (r.rd != r.wr) && !exp_halted) begin
         if (r.rd) begin
            exp_rd    = 1'b1;
            exp_rdata = (a < SCRATCH_WORDS) ? exp_scratch[a] : 16'hbeef;
         end else if (a == debug_io_pkg::ADDR_HALT || a == debug_io_pkg::ADDR_FAIL) begin
            exp_halted = 1'b1;
            exp_fail   = exp_fail + (a == debug_io_pkg::ADDR_FAIL);
         end else if (a == debug_io_pkg::ADDR_PASS) begin
            exp_pass = exp_pass + 16'd1;
         end else if (a >= debug_io_pkg::ADDR_PRINTA && a <= debug_io_pkg::ADDR_NEWLINE) begin
            p.kind = debug_io_pkg::print_kind_t'(3'(a - debug_io_pkg::ADDR_PRINTA));
            case (p.kind)
               debug_io_pkg::PRINT_ADDRESS: p.value = r.addr;   // Upper bits kept.
               debug_io_pkg::PRINT_SPACE:   p.value = 16'd32;
               debug_io_pkg::PRINT_NEWLINE: p.value = 16'd10;
               default:                     p.value = r.wdata;
            endcase
            if (exp_print.size() < PRINT_DEPTH) exp_print.push_back(p);
            else exp_print_ovf = 1'b1;
         end else begin
            l.addr = a;
            l.data = r.wdata;
            if (exp_log.size() < LOG_DEPTH) exp_log.push_back(l);
            else exp_log_ovf = 1'b1;
            if (a < SCRATCH_WORDS) exp_scratch[a] = r.wdata;
         end
      end
      @(negedge nw);
      req    = '0;
      exp_rd = 1'b0;
   endtask

   task automatic send(input debug_io_pkg::bus_req_t r);
      drive_req(r);
      repeat (2) @(negedge nw);                        // Effects visible after this.
   endtask

   task automatic write_io(input logic [15:0] addr, input logic [15:0] data);
      send(make_req(addr, data, 1'b1, 1'b0, 1'b1));
   endtask

   task automatic write_back_to_back(input logic [15:0] addr, input logic [15:0] data);
      drive_req(make_req(addr, data, 1'b1, 1'b0, 1'b1));  // Next request one cycle later.
   endtask

   task automatic read_io(input logic [15:0] addr);
      send(make_req(addr, 16'h0, 1'b1, 1'b1, 1'b0));
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial begin
      logic [15:0] ga;
      void'($urandom(56));                             // Seeds the run.
      rst       = 1'b1;
      req       = '0;
      print_pop = 1'b0;
      log_pop   = 1'b0;
      @(negedge nw);
      apply_reset();
      check_heads();
      for (int i = 0; i < SCRATCH_WORDS + 4; i++) read_io(16'(i));  // All read 0xbeef.
      for (int n = 0; n < 2; n++) begin                // Each print address, twice.
         for (int k = 0; k < 8; k++) begin
            write_io({6'($urandom), debug_io_pkg::ADDR_PRINTA + 10'(k)}, 16'($urandom));
         end
         drain_queues();
      end
      for (int i = 0; i < 16; i++) begin               // Generic writes, read back.
         ga = {6'($urandom), 10'($urandom_range(0, 2 * SCRATCH_WORDS - 1))};
         if (ga[9:0] == debug_io_pkg::ADDR_HALT) ga[9:0] = 10'h008;
         write_io(ga, 16'($urandom));
         read_io(ga);
         if (i % LOG_DEPTH == LOG_DEPTH - 1) drain_queues();
      end
      for (int i = 0; i < 12; i++) begin               // io low, both strobes, none.
         send(make_req({6'($urandom), (i < 6) ? debug_io_pkg::ADDR_FAIL : 10'h003},
                       16'($urandom), i % 3 != 0, i % 3 == 1, i % 3 != 2));
      end
      check_heads();
      for (int i = 0; i < PRINT_DEPTH + 2; i++) write_io(debug_io_pkg::ADDR_PRINTH, 16'(i));
      for (int i = 0; i < LOG_DEPTH + 2; i++) write_io(16'(i), 16'($urandom));
      drain_queues();
      repeat (3) write_io(debug_io_pkg::ADDR_PASS, 16'h1);
      write_back_to_back(debug_io_pkg::ADDR_FAIL, 16'h1);    // Halts the peripheral.
      write_back_to_back(debug_io_pkg::ADDR_PRINTC, 16'h41); // Fail still in the decoder.
      write_back_to_back(debug_io_pkg::ADDR_PASS, 16'h1);    // Halt event in flight.
      read_io(16'h2);
      write_io(16'h3, 16'h1234);
      check_heads();
      apply_reset();
      write_back_to_back(debug_io_pkg::ADDR_HALT, 16'h0);
      write_back_to_back(debug_io_pkg::ADDR_PASS, 16'h1);
      read_io(16'h0);
      check_heads();
      repeat (4) @(negedge nw);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* vlog.f */
hdl/debug_io_pkg.sv
hdl/io_decode.sv
hdl/event_fifo.sv
hdl/io_scratch.sv
hdl/halt_status.sv
hdl/debug_io.sv
tb/debug_io_tb.sv
